//--- sources.f
+incdir+hdl
hdl/a2card_pkg.sv
hdl/phase_sync.sv
hdl/bus_capture.sv
hdl/slot_decoder.sv
hdl/scratch_card.sv
hdl/timer_card.sv
hdl/bus_driver.sv
hdl/a2card_top.sv
tests/a2card_assertions.sv
tests/a2card_tb.sv

//--- tests/a2card_tb.sv
// Card core testbench
`include "a2card_config.svh"

module a2card_tb;
    import a2card_pkg::*;

    localparam int    CLK_PERIOD     = 40;
    localparam int    DRIVE_DELAY    = 5;
    localparam int    PLANNED_CYCLES = 50;
    localparam int    WATCHDOG_TIME  = (PLANNED_CYCLES + 20) * 24 * CLK_PERIOD;
    localparam addr_t SCRATCH_BASE   = 16'hC080 + 16'(`A2_SCRATCH_SLOT) * 16'h10;
    localparam addr_t TIMER_BASE     = 16'hC080 + 16'(`A2_TIMER_SLOT) * 16'h10;

    logic   clk_logic_w;
    logic   rst;
    logic   a2_phi1;
    addr_t  a2_addr;
    logic   a2_rw_n;
    data_t  a2_wdata;
    data_t  a2_rdata;
    logic   a2_data_oe;
    logic   a2_irq_n;
    integer seed;

    a2card_top i_dut (
        .clk_logic_w  (clk_logic_w),
        .rst_i        (rst),
        .a2_phi1_i    (a2_phi1),
        .a2_addr_i    (a2_addr),
        .a2_rw_n_i    (a2_rw_n),
        .a2_data_i    (a2_wdata),
        .a2_data_o    (a2_rdata),
        .a2_data_oe_o (a2_data_oe),
        .a2_irq_n_o   (a2_irq_n)
    );

    bind a2card_top a2card_assertions i_assertions (.*);

    initial begin
        clk_logic_w = 1'b0;
        forever #(CLK_PERIOD / 2) clk_logic_w = ~clk_logic_w;
    end

    // Phase 1 carries the address, phase 0 the write data
    task automatic bus_cycle(input addr_t addr, input logic rw_n, input data_t data);
        @(posedge clk_logic_w);
        #DRIVE_DELAY;
        a2_phi1 = 1'b1;
        a2_addr = addr;
        a2_rw_n = rw_n;
        repeat (12) @(posedge clk_logic_w);
        #DRIVE_DELAY;
        a2_phi1 = 1'b0;
        // Held through the next phi1 rise
        if (!rw_n) begin
            a2_wdata = data;
        end
        repeat (11) @(posedge clk_logic_w);
    endtask

    task automatic bus_write(input addr_t addr, input data_t data);
        bus_cycle(addr, 1'b0, data);
    endtask

    task automatic bus_read(input addr_t addr);
        bus_cycle(addr, 1'b1, 8'h00);
    endtask

    task automatic write_random(input addr_t addr);
        logic [31:0] value;
        value = $random(seed);
        bus_write(addr, value[7:0]);
    endtask

    initial begin
        #(WATCHDOG_TIME);
        $display("Simulation failed");
        $fatal(1, "Watchdog expired before the bus cycles completed");
    end

    initial begin
        wait (i_dut.i_assertions.fail_seen);
        $display("Simulation failed");
        $fatal(1, "Stopped at the first assertion failure");
    end

    initial begin
        seed     = 32'haaf0_0f09;
        rst      = 1'b1;
        a2_phi1  = 1'b1;
        a2_addr  = '0;
        a2_rw_n  = 1'b1;
        a2_wdata = '0;
        repeat (5) @(posedge clk_logic_w);
        #DRIVE_DELAY;
        rst = 1'b0;
        // Scratch bytes through direct offsets and aliases
        for (int round = 0; round < 2; round++) begin
            write_random(SCRATCH_BASE + 16'd0);
            write_random(SCRATCH_BASE + 16'd5);
            write_random(SCRATCH_BASE + 16'd14);
            write_random(SCRATCH_BASE + 16'd3);
            for (int off = 0; off < 4; off++) begin
                bus_read(SCRATCH_BASE + 16'(off));
            end
            bus_read(SCRATCH_BASE + 16'd9);
            bus_read(SCRATCH_BASE + 16'd14);
        end
        // Reads that no card claims
        bus_read(16'hC0A0);
        bus_read(16'hC0F3);
        bus_read(16'h1234);
        bus_read(TIMER_BASE + 16'd4);
        bus_read(TIMER_BASE + 16'd9);
        bus_read(TIMER_BASE + 16'd15);
        // Count of 5 with the interrupt enabled
        bus_write(TIMER_BASE + 16'd0, 8'd5);
        bus_write(TIMER_BASE + 16'd1, 8'd0);
        bus_write(TIMER_BASE + 16'd2, 8'h03);
        bus_read(TIMER_BASE + 16'd0);
        bus_read(TIMER_BASE + 16'd1);
        repeat (4) bus_read(TIMER_BASE + 16'd3);
        bus_write(TIMER_BASE + 16'd3, 8'h00);
        bus_read(TIMER_BASE + 16'd3);
        // Expiry with the interrupt disabled
        bus_write(TIMER_BASE + 16'd0, 8'd2);
        bus_write(TIMER_BASE + 16'd2, 8'h01);
        repeat (3) bus_read(TIMER_BASE + 16'd3);
        bus_write(TIMER_BASE + 16'd3, 8'h00);
        // Zero count runs out on the first tick
        bus_write(TIMER_BASE + 16'd0, 8'd0);
        bus_write(TIMER_BASE + 16'd2, 8'h03);
        bus_read(TIMER_BASE + 16'd3);
        bus_write(TIMER_BASE + 16'd2, 8'h00);
        bus_write(TIMER_BASE + 16'd3, 8'h00);
        bus_read(TIMER_BASE + 16'd3);
        bus_read(16'h0000);
        // Close the last bus cycle
        @(posedge clk_logic_w);
        #DRIVE_DELAY;
        a2_phi1 = 1'b1;
        repeat (24) @(posedge clk_logic_w);
        if (i_dut.i_assertions.fail_seen) begin
            $display("Simulation failed");
            $fatal(1, "An assertion failed during the run");
        end else begin
            $display("Simulation passed");
            $finish;
        end
    end

endmodule

//--- tests/a2card_assertions.sv
// Card core bus checks
`include "a2card_config.svh"

module a2card_assertions (
    input logic              clk_logic_w,
    input logic              rst_i,
    input logic              a2_phi1_i,
    input a2card_pkg::addr_t a2_addr_i,
    input logic              a2_rw_n_i,
    input a2card_pkg::data_t a2_data_i,
    input a2card_pkg::data_t a2_data_o,
    input logic              a2_data_oe_o,
    input logic              a2_irq_n_o
);
    import a2card_pkg::*;

    // Upper twelve address bits of each device-select range
    localparam logic [11:0] SCRATCH_PAGE = 12'hC08 + 12'(`A2_SCRATCH_SLOT);
    localparam logic [11:0] TIMER_PAGE   = 12'hC08 + 12'(`A2_TIMER_SLOT);

    logic   phi1_q;
    addr_t  cyc_addr;
    logic   cyc_rw_n;
    data_t  scratch_m [4];
    data_t  cnt_m [2];
    count_t load_m;
    count_t rises_m;
    logic   irq_en_m;
    logic   running_m;
    logic   expired_m;
    logic   scratch_hit;
    logic   timer_hit;
    logic   claimed;
    logic   data_chk;
    data_t  data_exp;
    logic   irq_n_exp;
    logic   fail_seen = 1'b0;

    assign scratch_hit = cyc_addr[15:4] == SCRATCH_PAGE;
    // Timer registers sit at offsets 0 to 3 only
    assign timer_hit   = cyc_addr[15:4] == TIMER_PAGE && cyc_addr[3:2] == 2'b00;
    assign claimed     = cyc_rw_n && (scratch_hit || timer_hit);
    // Control readback is left unchecked
    assign data_chk    = cyc_rw_n && (scratch_hit || (timer_hit && cyc_addr[1:0] != 2'd2));
    assign data_exp    = !timer_hit ? scratch_m[cyc_addr[1:0]] :
                         cyc_addr[1] ? {7'b0, expired_m} : cnt_m[cyc_addr[0]];
    assign irq_n_exp   = ~(irq_en_m & expired_m);

    always @(posedge clk_logic_w) begin : model_update
        logic   running_v;
        logic   expired_v;
        count_t rises_v;
        if (rst_i) begin
            phi1_q    <= 1'b1;
            cyc_addr  <= '0;
            cyc_rw_n  <= 1'b1;
            irq_en_m  <= 1'b0;
            running_m <= 1'b0;
            expired_m <= 1'b0;
            rises_m   <= '0;
        end else begin
            phi1_q <= a2_phi1_i;
            // Phase 0 start opens a new bus cycle
            if (phi1_q && !a2_phi1_i) begin
                cyc_addr <= a2_addr_i;
                cyc_rw_n <= a2_rw_n_i;
            end
            // Phase 0 end ticks the timer, then commits the write
            if (!phi1_q && a2_phi1_i) begin
                running_v = running_m;
                expired_v = expired_m;
                rises_v   = rises_m;
                if (running_v) begin
                    rises_v = rises_v + 16'd1;
                    if (rises_v >= load_m) begin
                        running_v = 1'b0;
                        expired_v = 1'b1;
                    end
                end
                if (!cyc_rw_n && scratch_hit) begin
                    scratch_m[cyc_addr[1:0]] <= a2_data_i;
                end
                if (!cyc_rw_n && timer_hit) begin
                    case (cyc_addr[1:0])
                        2'd2: begin
                            irq_en_m <= a2_data_i[1];
                            running_v = a2_data_i[0];
                            if (a2_data_i[0]) begin
                                expired_v = 1'b0;
                                rises_v   = '0;
                                load_m    <= {cnt_m[1], cnt_m[0]};
                            end
                        end
                        2'd3: expired_v = 1'b0;
                        default: cnt_m[cyc_addr[0]] <= a2_data_i;
                    endcase
                end
                running_m <= running_v;
                expired_m <= expired_v;
                rises_m   <= rises_v;
            end
        end
    end

    a_oe_claimed: assert property (@(posedge clk_logic_w) disable iff (rst_i)
        a2_data_oe_o |-> claimed)
        else begin
            fail_seen = 1'b1;
            $error("error a2_data_oe_o = %h on unclaimed cycle, address %h",
                   $sampled(a2_data_oe_o), $sampled(cyc_addr));
        end

    // Still driving when phi1 rises
    a_oe_held: assert property (@(posedge clk_logic_w) disable iff (rst_i)
        (!phi1_q && a2_phi1_i && claimed) |-> a2_data_oe_o)
        else begin
            fail_seen = 1'b1;
            $error("error a2_data_oe_o = %h at end of read, address %h",
                   $sampled(a2_data_oe_o), $sampled(cyc_addr));
        end

    a_read_data: assert property (@(posedge clk_logic_w) disable iff (rst_i)
        (!a2_phi1_i && a2_data_oe_o && data_chk) |-> a2_data_o == data_exp)
        else begin
            fail_seen = 1'b1;
            $error("error a2_data_o = %h, expected %h, address %h",
                   $sampled(a2_data_o), $sampled(data_exp), $sampled(cyc_addr));
        end

    a_irq_level: assert property (@(posedge clk_logic_w) disable iff (rst_i)
        !a2_phi1_i |-> a2_irq_n_o == irq_n_exp)
        else begin
            fail_seen = 1'b1;
            $error("error a2_irq_n_o = %h, expected %h",
                   $sampled(a2_irq_n_o), $sampled(irq_n_exp));
        end

endmodule

//--- hdl/a2card_top.sv
// Peripheral card core top level
module a2card_top (
    input  logic              clk_logic_w,
    input  logic              rst_i,
    input  logic              a2_phi1_i,
    input  a2card_pkg::addr_t a2_addr_i,
    input  logic              a2_rw_n_i,
    input  a2card_pkg::data_t a2_data_i,
    output a2card_pkg::data_t a2_data_o,
    output logic              a2_data_oe_o,
    output logic              a2_irq_n_o
);
    import a2card_pkg::*;

    logic       phi0_start_w;
    logic       phi0_end_w;
    bus_cycle_t cycle_w;
    logic       cycle_start_w;
    logic       cycle_end_w;
    card_sel_t  scratch_sel_w;
    card_sel_t  timer_sel_w;
    card_resp_t scratch_resp_w;
    card_resp_t timer_resp_w;

    // phi1 into the logic clock domain
    phase_sync i_phase_sync (
        .clk_logic_w  (clk_logic_w),
        .rst_i        (rst_i),
        .phi1_i       (a2_phi1_i),
        .phi0_o       (),
        .phi0_start_o (phi0_start_w),
        .phi0_end_o   (phi0_end_w)
    );

    bus_capture i_bus_capture (
        .clk_logic_w   (clk_logic_w),
        .rst_i         (rst_i),
        .phi0_start_i  (phi0_start_w),
        .phi0_end_i    (phi0_end_w),
        .addr_i        (a2_addr_i),
        .rw_n_i        (a2_rw_n_i),
        .data_i        (a2_data_i),
        .cycle_o       (cycle_w),
        .cycle_start_o (cycle_start_w),
        .cycle_end_o   (cycle_end_w)
    );

    slot_decoder i_slot_decoder (
        .clk_logic_w   (clk_logic_w),
        .rst_i         (rst_i),
        .cycle_i       (cycle_w),
        .cycle_end_i   (cycle_end_w),
        .scratch_sel_o (scratch_sel_w),
        .timer_sel_o   (timer_sel_w)
    );

    scratch_card i_scratch_card (
        .clk_logic_w   (clk_logic_w),
        .rst_i         (rst_i),
        .sel_i         (scratch_sel_w),
        .cycle_i       (cycle_w),
        .cycle_start_i (cycle_start_w),
        .cycle_end_i   (cycle_end_w),
        .resp_o        (scratch_resp_w)
    );

    // Each bus cycle end is one timer tick
    timer_card i_timer_card (
        .clk_logic_w   (clk_logic_w),
        .rst_i         (rst_i),
        .sel_i         (timer_sel_w),
        .cycle_i       (cycle_w),
        .cycle_start_i (cycle_start_w),
        .cycle_end_i   (cycle_end_w),
        .tick_i        (cycle_end_w),
        .resp_o        (timer_resp_w)
    );

    bus_driver i_bus_driver (
        .clk_logic_w    (clk_logic_w),
        .rst_i          (rst_i),
        .scratch_resp_i (scratch_resp_w),
        .timer_resp_i   (timer_resp_w),
        .data_o         (a2_data_o),
        .data_oe_o      (a2_data_oe_o),
        .irq_n_o        (a2_irq_n_o)
    );

endmodule

//--- hdl/bus_driver.sv
// Bus data and interrupt driver
`include "a2card_config.svh"

module bus_driver (
    input  logic                   clk_logic_w,
    input  logic                   rst_i,
    input  a2card_pkg::card_resp_t scratch_resp_i,
    input  a2card_pkg::card_resp_t timer_resp_i,
    output a2card_pkg::data_t      data_o,
    output logic                   data_oe_o,
    output logic                   irq_n_o
);

    logic any_rd;
    logic all_irq_n;

    assign any_rd    = scratch_resp_i.rd_en | timer_resp_i.rd_en;
    // Open-drain style wired AND of the card interrupts
    assign all_irq_n = scratch_resp_i.irq_n & timer_resp_i.irq_n;

    always_ff @(posedge clk_logic_w) begin
        if (rst_i) begin
            data_o    <= '0;
            data_oe_o <= 1'b0;
            irq_n_o   <= 1'b1;
        end else begin
            // Timer wins if both cards claim the cycle
            data_o    <= timer_resp_i.rd_en ? timer_resp_i.data : scratch_resp_i.data;
            data_oe_o <= any_rd & `A2_DATA_OUT_ENABLE;
            irq_n_o   <= all_irq_n | ~`A2_IRQ_OUT_ENABLE;
        end
    end

endmodule

//--- hdl/timer_card.sv
// Bus-cycle countdown timer card
module timer_card (
    input  logic                   clk_logic_w,
    input  logic                   rst_i,
    input  a2card_pkg::card_sel_t  sel_i,
    input  a2card_pkg::bus_cycle_t cycle_i,
    input  logic                   cycle_start_i,
    input  logic                   cycle_end_i,
    input  logic                   tick_i,
    output a2card_pkg::card_resp_t resp_o
);
    import a2card_pkg::*;

    data_t        count_lo_r;
    data_t        count_hi_r;
    logic         irq_en_r;
    count_t       counter_r;
    timer_state_t state_r;
    logic         rd_en_r;
    data_t        rd_data_r;
    logic         reg_hit;
    data_t        rd_mux;

    // Only offsets 0 to 3 are implemented
    assign reg_hit = sel_i.sel && (sel_i.reg_off[3:2] == 2'b00);

    always_comb begin
        case (sel_i.reg_off[1:0])
            2'd0:    rd_mux = count_lo_r;
            2'd1:    rd_mux = count_hi_r;
            2'd2:    rd_mux = {6'b0, irq_en_r, state_r == TIMER_COUNTING};
            default: rd_mux = {7'b0, state_r == TIMER_EXPIRED};
        endcase
    end

    // Writes land one cycle after a tick, so the two never collide
    always_ff @(posedge clk_logic_w) begin
        if (rst_i) begin
            count_lo_r <= '0;
            count_hi_r <= '0;
            irq_en_r   <= 1'b0;
            counter_r  <= '0;
            state_r    <= TIMER_IDLE;
        end else if (sel_i.wr_stb && reg_hit) begin
            case (sel_i.reg_off[1:0])
                2'd0: count_lo_r <= cycle_i.data;
                2'd1: count_hi_r <= cycle_i.data;
                2'd2: begin
                    irq_en_r <= cycle_i.data[1];
                    if (cycle_i.data[0]) begin
                        counter_r <= {count_hi_r, count_lo_r};
                        state_r   <= TIMER_COUNTING;
                    end else if (state_r == TIMER_COUNTING) begin
                        state_r <= TIMER_IDLE;
                    end
                end
                // Any write to status acknowledges expiry
                default: if (state_r == TIMER_EXPIRED) state_r <= TIMER_IDLE;
            endcase
        end else if (tick_i && state_r == TIMER_COUNTING) begin
            // Counts of 0 and 1 both run out on this tick
            if (counter_r <= 16'd1) begin
                counter_r <= '0;
                state_r   <= TIMER_EXPIRED;
            end else begin
                counter_r <= counter_r - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_logic_w) begin
        if (rst_i) begin
            rd_en_r   <= 1'b0;
            rd_data_r <= '0;
        end else if (cycle_start_i && reg_hit && cycle_i.rw_n) begin
            rd_en_r   <= 1'b1;
            rd_data_r <= rd_mux;
        end else if (cycle_end_i) begin
            rd_en_r <= 1'b0;
        end
    end

    always_comb begin
        resp_o.rd_en = rd_en_r;
        resp_o.data  = rd_data_r;
        resp_o.irq_n = ~(irq_en_r && state_r == TIMER_EXPIRED);
    end

endmodule

//--- hdl/scratch_card.sv
// Scratch register card
module scratch_card (
    input  logic                   clk_logic_w,
    input  logic                   rst_i,
    input  a2card_pkg::card_sel_t  sel_i,
    input  a2card_pkg::bus_cycle_t cycle_i,
    input  logic                   cycle_start_i,
    input  logic                   cycle_end_i,
    output a2card_pkg::card_resp_t resp_o
);
    import a2card_pkg::*;

    data_t regs_r [4];
    logic  rd_en_r;
    data_t rd_data_r;

    // Low two offset bits pick the byte, so the range aliases
    always_ff @(posedge clk_logic_w) begin
        if (rst_i) begin
            for (int i = 0; i < 4; i++) begin
                regs_r[i] <= '0;
            end
            rd_en_r   <= 1'b0;
            rd_data_r <= '0;
        end else begin
            if (sel_i.wr_stb) begin
                regs_r[sel_i.reg_off[1:0]] <= cycle_i.data;
            end
            if (cycle_start_i && sel_i.sel && cycle_i.rw_n) begin
                rd_en_r   <= 1'b1;
                rd_data_r <= regs_r[sel_i.reg_off[1:0]];
            end else if (cycle_end_i) begin
                rd_en_r <= 1'b0;
            end
        end
    end

    always_comb begin
        resp_o.rd_en = rd_en_r;
        resp_o.data  = rd_data_r;
        // No interrupt source on this card
        resp_o.irq_n = 1'b1;
    end

endmodule

//--- hdl/slot_decoder.sv
// Slot device-select decoder
`include "a2card_config.svh"

module slot_decoder (
    input  logic                   clk_logic_w,
    input  logic                   rst_i,
    input  a2card_pkg::bus_cycle_t cycle_i,
    input  logic                   cycle_end_i,
    output a2card_pkg::card_sel_t  scratch_sel_o,
    output a2card_pkg::card_sel_t  timer_sel_o
);
    import a2card_pkg::*;

    logic scratch_hit;
    logic timer_hit;
    logic scratch_wr_r;
    logic timer_wr_r;

    // Slot n owns C080 + 16n .. C08F + 16n
    function automatic logic slot_hit(input addr_t addr, input logic [2:0] slot);
        slot_hit = (addr[15:4] == {9'h181, slot});
    endfunction

    assign scratch_hit = slot_hit(cycle_i.addr, 3'(`A2_SCRATCH_SLOT));
    assign timer_hit   = slot_hit(cycle_i.addr, 3'(`A2_TIMER_SLOT));

    // One commit per write cycle, after the data is captured
    always_ff @(posedge clk_logic_w) begin
        if (rst_i) begin
            scratch_wr_r <= 1'b0;
            timer_wr_r   <= 1'b0;
        end else begin
            scratch_wr_r <= cycle_end_i & scratch_hit & ~cycle_i.rw_n;
            timer_wr_r   <= cycle_end_i & timer_hit & ~cycle_i.rw_n;
        end
    end

    always_comb begin
        scratch_sel_o.sel     = scratch_hit;
        scratch_sel_o.wr_stb  = scratch_wr_r;
        scratch_sel_o.reg_off = cycle_i.addr[3:0];
        timer_sel_o.sel       = timer_hit;
        timer_sel_o.wr_stb    = timer_wr_r;
        timer_sel_o.reg_off   = cycle_i.addr[3:0];
    end

endmodule

//--- hdl/bus_capture.sv
// Bus cycle capture
module bus_capture (
    input  logic                   clk_logic_w,
    input  logic                   rst_i,
    input  logic                   phi0_start_i,
    input  logic                   phi0_end_i,
    input  a2card_pkg::addr_t      addr_i,
    input  logic                   rw_n_i,
    input  a2card_pkg::data_t      data_i,
    output a2card_pkg::bus_cycle_t cycle_o,
    output logic                   cycle_start_o,
    output logic                   cycle_end_o
);

    // Address and direction are stable when phase 0 begins
    always_ff @(posedge clk_logic_w) begin
        if (rst_i) begin
            cycle_o.addr <= '0;
            cycle_o.rw_n <= 1'b1;
        end else if (phi0_start_i) begin
            cycle_o.addr <= addr_i;
            cycle_o.rw_n <= rw_n_i;
        end
    end

    // Write data is only valid late in phase 0
    always_ff @(posedge clk_logic_w) begin
        if (rst_i) begin
            cycle_o.data <= '0;
        end else if (phi0_end_i) begin
            cycle_o.data <= data_i;
        end
    end

    // Event pulses trail the captures by one cycle
    always_ff @(posedge clk_logic_w) begin
        if (rst_i) begin
            cycle_start_o <= 1'b0;
            cycle_end_o   <= 1'b0;
        end else begin
            cycle_start_o <= phi0_start_i;
            cycle_end_o   <= phi0_end_i;
        end
    end

endmodule

//--- hdl/phase_sync.sv
// Bus clock synchronizer
`include "a2card_config.svh"

module phase_sync (
    input  logic clk_logic_w,
    input  logic rst_i,
    input  logic phi1_i,
    output logic phi0_o,
    output logic phi0_start_o,
    output logic phi0_end_o
);

    logic [`A2_SYNC_STAGES-1:0] sync_r;
    logic                       phi1_r;
    logic                       phi1_sync;

    assign phi1_sync = sync_r[`A2_SYNC_STAGES-1];

    // Idle bus is assumed to be in phase 1
    always_ff @(posedge clk_logic_w) begin
        if (rst_i) begin
            sync_r       <= '1;
            phi1_r       <= 1'b1;
            phi0_start_o <= 1'b0;
            phi0_end_o   <= 1'b0;
        end else begin
            sync_r       <= {sync_r[`A2_SYNC_STAGES-2:0], phi1_i};
            phi1_r       <= phi1_sync;
            // Edge pulses line up with the phi1_r update
            phi0_start_o <= phi1_r & ~phi1_sync;
            phi0_end_o   <= ~phi1_r & phi1_sync;
        end
    end

    // Phase 0 is the inverse of phi1
    assign phi0_o = ~phi1_r;

endmodule

//--- hdl/a2card_pkg.sv
// Card core types
package a2card_pkg;

    typedef logic [15:0] addr_t;
    typedef logic [7:0] data_t;
    // Offset inside a slot's device-select range
    typedef logic [3:0] reg_off_t;
    typedef logic [15:0] count_t;

    // One bus cycle as seen at the phase edges
    typedef struct packed {
        addr_t addr;
        logic  rw_n;
        data_t data;
    } bus_cycle_t;

    // Decoder to card
    typedef struct packed {
        logic     sel;
        logic     wr_stb;
        reg_off_t reg_off;
    } card_sel_t;

    // Card to bus driver
    typedef struct packed {
        logic  rd_en;
        data_t data;
        logic  irq_n;
    } card_resp_t;

    typedef enum logic [1:0] {
        TIMER_IDLE,
        TIMER_COUNTING,
        TIMER_EXPIRED
    } timer_state_t;

endpackage

//--- hdl/a2card_config.svh
// Card core configuration
`ifndef A2CARD_CONFIG_SVH
`define A2CARD_CONFIG_SVH

// Slot assignment of the two cards
`define A2_SCRATCH_SLOT 3
`define A2_TIMER_SLOT 4

// Flops in the phi1 synchronizer
`define A2_SYNC_STAGES 2

// Bus drive permissions
// Clear to keep the card off the data bus
`define A2_DATA_OUT_ENABLE 1'b1
// Clear to keep the card off the IRQ line
`define A2_IRQ_OUT_ENABLE 1'b1

`endif
